// File: list.f
+incdir+src
src/retire_stats_pkg.sv
src/collection_window.sv
src/instr_mix_classifier.sv
src/mix_counters.sv
src/retire_stats.sv
tests/retire_stats_props.sv
tests/retire_stats_tb.sv

// File: Makefile
# Verilator simulation of the retire-stream monitor
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= retire_stats_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/retire_stats_tb.sv
////////////////////////////////////////////////////////////
// Directed testbench for retire_stats with two retire ports
// Expected counts come from a reference model of the class
// and window rules; ports above 1 are not driven
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "retire_stats_defs.svh"

module retire_stats_tb;
    import retire_stats_pkg::*;

    localparam int CLK_HALF = 10;
    localparam int DRIVE_DELAY = 2;
    localparam logic [31:0] LFSR_SEED = 32'd60;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int RANDOM_CYCLES = 32;
    // Reset plus each test, in clock cycles
    localparam int TEST_CYCLES = 16 + 13 + 23 + 47 + 20 + 77;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    // Sample instructions, one per class
    localparam logic [31:0] I_ADD = 32'h00B50533;
    localparam logic [31:0] I_ADDI_B25 = 32'h02050513;
    localparam logic [31:0] I_BEQ = 32'h00000463;
    localparam logic [31:0] I_JAL = 32'h008000EF;
    localparam logic [31:0] I_MUL = 32'h02B50533;
    localparam logic [31:0] I_DIV = 32'h02B54533;
    localparam logic [31:0] I_LW = 32'h0005A503;
    localparam logic [31:0] I_SW = 32'h00A5A023;
    localparam logic [31:0] I_AMO = 32'h00B6252F;
    localparam logic [31:0] I_FADD = 32'h00208053;
    localparam logic [31:0] I_ECALL = 32'h00000073;

    logic clk;
    logic reset;
    instr_t retire_instruction [`RS_RETIRE_PORTS];
    port_mask_t retire_valid;
    stat_sel_t stat_sel;
    logic collecting;
    logic done;
    count_t stat_value;

    logic [31:0] model_counters [`RS_NUM_STATS];
    logic model_collecting;
    logic model_done;
    logic [31:0] lfsr_state;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_count = 0;

    retire_stats i_dut (
        .clk                (clk),
        .reset              (reset),
        .retire_instruction (retire_instruction),
        .retire_valid       (retire_valid),
        .stat_sel           (stat_sel),
        .collecting         (collecting),
        .done               (done),
        .stat_value         (stat_value)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and stimulus helpers

    // Class bits of one valid instruction
    function automatic logic [8:0] classify(input logic [31:0] w);
        logic [8:0] c;
        c = '0;
        c[`RS_STAT_RETIRED] = 1'b1;
        case (w[6:2])
            `RS_OP_ARITH: begin
                if (w[25] && !w[14]) begin
                    c[`RS_STAT_MUL] = 1'b1;
                end else if (w[25]) begin
                    c[`RS_STAT_DIV] = 1'b1;
                end else begin
                    c[`RS_STAT_ALU] = 1'b1;
                end
            end
            `RS_OP_ARITH_IMM, `RS_OP_AUIPC, `RS_OP_LUI: c[`RS_STAT_ALU] = !w[25];
            `RS_OP_BRANCH, `RS_OP_JAL, `RS_OP_JALR: c[`RS_STAT_BR] = 1'b1;
            `RS_OP_LOAD, `RS_OP_FP_LOAD: c[`RS_STAT_LOAD] = 1'b1;
            `RS_OP_STORE, `RS_OP_FP_STORE: c[`RS_STAT_STORE] = 1'b1;
            `RS_OP_AMO: begin
                c[`RS_STAT_LOAD] = 1'b1;
                c[`RS_STAT_STORE] = 1'b1;
            end
            `RS_OP_FMADD, `RS_OP_FMSUB, `RS_OP_FNMSUB, `RS_OP_FNMADD, `RS_OP_OP_FP: begin
                c[`RS_STAT_FPU] = 1'b1;
            end
            `RS_OP_SYSTEM, `RS_OP_FENCE: c[`RS_STAT_MISC] = 1'b1;
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Random word that is never a marker
    task automatic random_word(output logic [31:0] w);
        random_bits(32, w);
        if (w == `RS_START_NOP || w == `RS_END_NOP) begin
            w[31] = ~w[31];
        end
    endtask

    // One retire cycle, the model steps with it
    task automatic drive_cycle(input logic [31:0] w0, input logic [31:0] w1,
                               input logic [1:0] valid);
        logic [8:0] cls;
        logic [31:0] w;
        logic [31:0] cycle_counts [`RS_NUM_STATS];
        logic seen_start;
        logic seen_end;
        seen_start = 1'b0;
        seen_end = 1'b0;
        for (int s = 0; s < `RS_NUM_STATS; s++) begin
            cycle_counts[s] = '0;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        retire_instruction[0] = w0;
        retire_instruction[1] = w1;
        retire_valid = valid;
        for (int p = 0; p < 2; p++) begin
            w = (p == 0) ? w0 : w1;
            if (valid[p]) begin
                cls = classify(w);
                seen_start = seen_start | (w == `RS_START_NOP);
                seen_end = seen_end | (w == `RS_END_NOP);
                for (int s = 0; s < `RS_NUM_STATS; s++) begin
                    cycle_counts[s] = cycle_counts[s] + 32'(cls[s]);
                end
            end
        end
        // End wins over start
        if (seen_end) begin
            model_collecting = 1'b0;
            model_done = 1'b1;
        end else if (seen_start) begin
            model_collecting = 1'b1;
            model_done = 1'b0;
            model_counters = cycle_counts;
        end else if (model_collecting) begin
            for (int s = 0; s < `RS_NUM_STATS; s++) begin
                model_counters[s] = model_counters[s] + cycle_counts[s];
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(32'h0, 32'h0, 2'b00);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    // Window flags, then every counter and one select out of range
    task automatic check_counters();
        logic [31:0] expected;
        idle_cycles(2);
        @(negedge clk);
        check_value("collecting", 32'(collecting), 32'(model_collecting));
        check_value("done", 32'(done), 32'(model_done));
        for (int s = 0; s <= `RS_NUM_STATS; s++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            stat_sel = stat_sel_t'(s);
            expected = 32'h0;
            if (s < `RS_NUM_STATS) begin
                expected = model_counters[s];
            end
            @(negedge clk);
            check_value($sformatf("stat_value[%0d]", s), stat_value, expected);
        end
        // Leave a live counter selected between checks
        @(posedge clk);
        #DRIVE_DELAY;
        stat_sel = stat_sel_t'(`RS_STAT_RETIRED);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("%s finished with %0d errors", name, error_count - errors_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_after_reset();
        int errors_before;
        errors_before = error_count;
        check_counters();
        report_test("after reset", errors_before);
    endtask

    task automatic test_each_class();
        int errors_before;
        errors_before = error_count;
        // Port 1 holds an instruction but stays invalid
        drive_cycle(`RS_START_NOP, I_ADD, 2'b01);
        drive_cycle(I_ADD, 32'h0, 2'b01);
        drive_cycle(I_BEQ, 32'h0, 2'b01);
        drive_cycle(I_MUL, 32'h0, 2'b01);
        drive_cycle(I_DIV, 32'h0, 2'b01);
        drive_cycle(I_LW, 32'h0, 2'b01);
        drive_cycle(I_SW, 32'h0, 2'b01);
        drive_cycle(I_FADD, 32'h0, 2'b01);
        drive_cycle(I_ECALL, 32'h0, 2'b01);
        drive_cycle(`RS_END_NOP, 32'h0, 2'b01);
        check_counters();
        report_test("one of each class", errors_before);
    endtask

    task automatic test_out_of_window();
        int errors_before;
        errors_before = error_count;
        drive_cycle(I_ADD, I_LW, 2'b11);
        drive_cycle(I_MUL, I_ECALL, 2'b11);
        check_counters();
        // The add next to the end marker is dropped
        drive_cycle(`RS_START_NOP, 32'h0, 2'b01);
        drive_cycle(I_BEQ, I_SW, 2'b11);
        drive_cycle(I_DIV, I_FADD, 2'b11);
        drive_cycle(`RS_END_NOP, I_ADD, 2'b11);
        check_counters();
        drive_cycle(I_JAL, I_AMO, 2'b11);
        drive_cycle(I_LW, I_ADD, 2'b10);
        check_counters();
        report_test("out of window", errors_before);
    endtask

    task automatic test_multi_port();
        int errors_before;
        errors_before = error_count;
        drive_cycle(`RS_START_NOP, I_AMO, 2'b11);
        drive_cycle(I_MUL, I_DIV, 2'b11);
        drive_cycle(I_ADDI_B25, I_ADD, 2'b11);
        // Markers on invalid ports
        drive_cycle(I_LW, `RS_END_NOP, 2'b01);
        drive_cycle(`RS_START_NOP, I_SW, 2'b10);
        idle_cycles(1);
        @(negedge clk);
        check_value("collecting", 32'(collecting), 32'(model_collecting));
        drive_cycle(`RS_START_NOP, `RS_END_NOP, 2'b11);
        check_counters();
        report_test("multi port", errors_before);
    endtask

    task automatic test_restart();
        int errors_before;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] v;
        errors_before = error_count;
        drive_cycle(`RS_START_NOP, I_FADD, 2'b11);
        drive_cycle(I_ADD, I_BEQ, 2'b11);
        drive_cycle(I_ECALL, I_LW, 2'b11);
        check_counters();
        drive_cycle(I_SW, `RS_START_NOP, 2'b11);
        drive_cycle(I_JAL, 32'h0, 2'b01);
        check_counters();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            random_word(w0);
            random_word(w1);
            random_bits(2, v);
            drive_cycle(w0, w1, v[1:0]);
        end
        drive_cycle(`RS_END_NOP, 32'h0, 2'b01);
        check_counters();
        report_test("restart", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        stat_sel = '0;
        retire_valid = '0;
        for (int p = 0; p < `RS_RETIRE_PORTS; p++) begin
            retire_instruction[p] = '0;
        end
        lfsr_state = LFSR_SEED;
        model_collecting = 1'b0;
        model_done = 1'b0;
        for (int s = 0; s < `RS_NUM_STATS; s++) begin
            model_counters[s] = '0;
        end
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        test_after_reset();
        test_each_class();
        test_out_of_window();
        test_multi_port();
        test_restart();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/retire_stats_props.sv
////////////////////////////////////////////////////////////
// Window and counter properties, bound into retire_stats
// Counter stability holds only while stat_sel is unchanged
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module retire_stats_props (
    input logic                         clk,
    input logic                         reset,
    input logic                         collecting,
    input logic                         done,
    input retire_stats_pkg::stat_sel_t  stat_sel,
    input retire_stats_pkg::count_t     stat_value
);

    // Window FSM never in two states at once
    assert property (@(posedge clk) disable iff (reset) !(collecting && done))
        else $error("collecting and done are both high");

    assert property (@(posedge clk) reset |=> !collecting && !done)
        else $error("window flags not low in the cycle after reset");

    // Closed window freezes the selected counter
    assert property (@(posedge clk) disable iff (reset)
        !$past(collecting) && !$past(reset) && stat_sel == $past(stat_sel)
        |-> stat_value == $past(stat_value))
        else $error("counter changed while the window was closed");

endmodule

bind retire_stats retire_stats_props i_props (
    .clk        (clk),
    .reset      (reset),
    .collecting (collecting),
    .done       (done),
    .stat_sel   (stat_sel),
    .stat_value (stat_value)
);

`default_nettype wire

// File: src/retire_stats.sv
////////////////////////////////////////////////////////////
// Retire-stream instruction mix monitor, top level
// Counts retired instructions per class between marker NOPs
// stat_value lags a retire by two cycles, stat_sel is comb
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "retire_stats_defs.svh"

module retire_stats (
    input  logic                         clk,
    input  logic                         reset,
    input  retire_stats_pkg::instr_t     retire_instruction [`RS_RETIRE_PORTS],
    input  retire_stats_pkg::port_mask_t retire_valid,
    input  retire_stats_pkg::stat_sel_t  stat_sel,
    output logic                         collecting,
    output logic                         done,
    output retire_stats_pkg::count_t     stat_value
);
    import retire_stats_pkg::*;

    logic window_start;
    port_count_t class_counts [`RS_NUM_STATS];

    // Window FSM
    collection_window i_collection_window (
        .clk                (clk),
        .reset              (reset),
        .retire_instruction (retire_instruction),
        .retire_valid       (retire_valid),
        .collecting         (collecting),
        .done               (done),
        .window_start       (window_start)
    );

    // Per-cycle class totals
    instr_mix_classifier i_instr_mix_classifier (
        .clk                (clk),
        .reset              (reset),
        .retire_instruction (retire_instruction),
        .retire_valid       (retire_valid),
        .class_counts       (class_counts)
    );

    // Counters and readout
    mix_counters i_mix_counters (
        .clk          (clk),
        .reset        (reset),
        .collecting   (collecting),
        .window_start (window_start),
        .class_counts (class_counts),
        .stat_sel     (stat_sel),
        .stat_value   (stat_value)
    );

endmodule

`default_nettype wire

// File: src/mix_counters.sv
////////////////////////////////////////////////////////////
// Window-gated class counters with a select readout
// window_start loads the incoming counts instead of adding
// Counters wrap at RS_COUNT_WIDTH bits
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "retire_stats_defs.svh"

module mix_counters (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          collecting,
    input  logic                          window_start,
    input  retire_stats_pkg::port_count_t class_counts [`RS_NUM_STATS],
    input  retire_stats_pkg::stat_sel_t   stat_sel,
    output retire_stats_pkg::count_t      stat_value
);
    import retire_stats_pkg::*;

    count_t counters [`RS_NUM_STATS];

    ////////////////////////////////////////////////////////////
    // Accumulate
    always_ff @(posedge clk) begin
        if (reset) begin
            counters <= '{default: '0};
        end else begin
            for (int s = 0; s < `RS_NUM_STATS; s++) begin
                // Restart takes priority, count starts at the start cycle
                if (window_start) begin
                    counters[s] <= count_t'(class_counts[s]);
                end else if (collecting) begin
                    counters[s] <= counters[s] + count_t'(class_counts[s]);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Readout
    always_comb begin
        stat_value = '0;
        if (stat_sel < stat_sel_t'(`RS_NUM_STATS)) begin
            stat_value = counters[stat_sel];
        end
    end

endmodule

`default_nettype wire

// File: src/instr_mix_classifier.sv
////////////////////////////////////////////////////////////
// Sorts each valid retire port into the instruction classes
// and registers the per-class totals for the cycle
// AMO counts as both load and store
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "retire_stats_defs.svh"

module instr_mix_classifier (
    input  logic                          clk,
    input  logic                          reset,
    input  retire_stats_pkg::instr_t      retire_instruction [`RS_RETIRE_PORTS],
    input  retire_stats_pkg::port_mask_t  retire_valid,
    output retire_stats_pkg::port_count_t class_counts [`RS_NUM_STATS]
);
    import retire_stats_pkg::*;

    // One class bit per stat, per port
    logic [`RS_NUM_STATS-1:0] class_bits [`RS_RETIRE_PORTS];
    port_count_t class_sum [`RS_NUM_STATS];

    ////////////////////////////////////////////////////////////
    // Per-port decode
    for (genvar p = 0; p < `RS_RETIRE_PORTS; p++) begin : gen_port
        logic [4:0] opcode;
        logic valid;
        logic is_mul;
        logic is_div;

        assign opcode = retire_instruction[p][6:2];
        assign valid = retire_valid[p];

        // M extension funct7 bit and the divide bit of funct3
        assign is_mul = retire_instruction[p][25] & ~retire_instruction[p][14];
        assign is_div = retire_instruction[p][25] & retire_instruction[p][14];

        // Immediate ops with bit 25 set also drop out of ALU
        assign class_bits[p][`RS_STAT_ALU] = valid & ~(is_mul | is_div)
            & (opcode inside {`RS_OP_ARITH, `RS_OP_ARITH_IMM, `RS_OP_AUIPC, `RS_OP_LUI});

        assign class_bits[p][`RS_STAT_BR] = valid
            & (opcode inside {`RS_OP_BRANCH, `RS_OP_JAL, `RS_OP_JALR});

        assign class_bits[p][`RS_STAT_MUL] = valid & (opcode == `RS_OP_ARITH) & is_mul;

        assign class_bits[p][`RS_STAT_DIV] = valid & (opcode == `RS_OP_ARITH) & is_div;

        assign class_bits[p][`RS_STAT_LOAD] = valid
            & (opcode inside {`RS_OP_LOAD, `RS_OP_FP_LOAD, `RS_OP_AMO});

        assign class_bits[p][`RS_STAT_STORE] = valid
            & (opcode inside {`RS_OP_STORE, `RS_OP_FP_STORE, `RS_OP_AMO});

        assign class_bits[p][`RS_STAT_FPU] = valid
            & (opcode inside {`RS_OP_FMADD, `RS_OP_FMSUB, `RS_OP_FNMSUB,
                              `RS_OP_FNMADD, `RS_OP_OP_FP});

        assign class_bits[p][`RS_STAT_MISC] = valid
            & (opcode inside {`RS_OP_SYSTEM, `RS_OP_FENCE});

        assign class_bits[p][`RS_STAT_RETIRED] = valid;
    end

    ////////////////////////////////////////////////////////////
    // Sum across ports
    always_comb begin
        for (int s = 0; s < `RS_NUM_STATS; s++) begin
            class_sum[s] = '0;
            for (int p = 0; p < `RS_RETIRE_PORTS; p++) begin
                class_sum[s] = class_sum[s] + port_count_t'(class_bits[p][s]);
            end
        end
    end

    // Counts appear the cycle after retire
    always_ff @(posedge clk) begin
        if (reset) begin
            class_counts <= '{default: '0};
        end else begin
            class_counts <= class_sum;
        end
    end

endmodule

`default_nettype wire

// File: src/collection_window.sv
////////////////////////////////////////////////////////////
// Tracks the collection window from marker NOPs
// End marker wins over start marker in the same cycle
// collecting/done follow one cycle after the marker retires
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "retire_stats_defs.svh"

module collection_window (
    input  logic                        clk,
    input  logic                        reset,
    input  retire_stats_pkg::instr_t    retire_instruction [`RS_RETIRE_PORTS],
    input  retire_stats_pkg::port_mask_t retire_valid,
    output logic                        collecting,
    output logic                        done,
    output logic                        window_start
);
    import retire_stats_pkg::*;

    window_state_t state;
    window_state_t next_state;
    logic sees_start;
    logic sees_end;

    // Marker detect, any valid port
    always_comb begin
        sees_start = 1'b0;
        sees_end = 1'b0;
        for (int i = 0; i < `RS_RETIRE_PORTS; i++) begin
            sees_start |= retire_valid[i] & (retire_instruction[i] == `RS_START_NOP);
            sees_end |= retire_valid[i] & (retire_instruction[i] == `RS_END_NOP);
        end
    end

    // Same rules from every state
    always_comb begin
        next_state = state;
        if (sees_end) begin
            next_state = WIN_DONE;
        end else if (sees_start) begin
            next_state = WIN_COLLECTING;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WIN_IDLE;
            window_start <= 1'b0;
        end else begin
            state <= next_state;
            // Pulses on every (re)entry, also while already collecting
            window_start <= sees_start & ~sees_end;
        end
    end

    assign collecting = (state == WIN_COLLECTING);
    assign done = (state == WIN_DONE);

endmodule

`default_nettype wire

// File: src/retire_stats_pkg.sv
////////////////////////////////////////////////////////////
// Shared types for the retire-stream monitor
// Widths follow the defines in the header
////////////////////////////////////////////////////////////
`default_nettype none

`include "retire_stats_defs.svh"

package retire_stats_pkg;

    ////////////////////////////////////////////////////////////
    // Retire port types

    // One retired instruction word
    typedef logic [31:0] instr_t;

    // One valid bit per retire port
    typedef logic [`RS_RETIRE_PORTS-1:0] port_mask_t;

    // Per-class count for one cycle, 0 up to the port count
    typedef logic [$clog2(`RS_RETIRE_PORTS + 1)-1:0] port_count_t;

    ////////////////////////////////////////////////////////////
    // Counter types

    typedef logic [`RS_COUNT_WIDTH-1:0] count_t;

    // Selects values above the last stat index read as zero
    typedef logic [3:0] stat_sel_t;

    ////////////////////////////////////////////////////////////
    // Window FSM

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_COLLECTING,
        WIN_DONE
    } window_state_t;

endpackage

`default_nettype wire

// File: src/retire_stats_defs.svh
////////////////////////////////////////////////////////////
// Retire-stream monitor constants
// Marker NOPs are addi x0,x0,12 and addi x0,x0,13
// Opcodes are instruction bits 6 to 2 (RV32 major opcode)
////////////////////////////////////////////////////////////
`ifndef RETIRE_STATS_DEFS_SVH
`define RETIRE_STATS_DEFS_SVH

`define RS_RETIRE_PORTS 2
`define RS_COUNT_WIDTH 32
`define RS_NUM_STATS 9

// Collection window markers
`define RS_START_NOP 32'h00C00013
`define RS_END_NOP 32'h00D00013

// Major opcodes
`define RS_OP_ARITH 5'b01100
`define RS_OP_ARITH_IMM 5'b00100
`define RS_OP_AUIPC 5'b00101
`define RS_OP_LUI 5'b01101
`define RS_OP_BRANCH 5'b11000
`define RS_OP_JAL 5'b11011
`define RS_OP_JALR 5'b11001
`define RS_OP_LOAD 5'b00000
`define RS_OP_FP_LOAD 5'b00001
`define RS_OP_AMO 5'b01011
`define RS_OP_STORE 5'b01000
`define RS_OP_FP_STORE 5'b01001
`define RS_OP_FMADD 5'b10000
`define RS_OP_FMSUB 5'b10001
`define RS_OP_FNMSUB 5'b10010
`define RS_OP_FNMADD 5'b10011
`define RS_OP_OP_FP 5'b10100
`define RS_OP_SYSTEM 5'b11100
`define RS_OP_FENCE 5'b00011

// Counter indices, also the stat_sel values
`define RS_STAT_ALU 0
`define RS_STAT_BR 1
`define RS_STAT_MUL 2
`define RS_STAT_DIV 3
`define RS_STAT_LOAD 4
`define RS_STAT_STORE 5
`define RS_STAT_FPU 6
`define RS_STAT_MISC 7
`define RS_STAT_RETIRED 8

`endif
